//--- include/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define DATA_W     32
`define REG_ADDR_W 5
`define REG_NUM    32

// patterns over inst[31:15], ? bits belong to operands
`define OP_ADD_W     17'b000000_0000_01_00000
`define OP_SUB_W     17'b000000_0000_01_00010
`define OP_SLT       17'b000000_0000_01_00100
`define OP_SLTU      17'b000000_0000_01_00101
`define OP_NOR       17'b000000_0000_01_01000
`define OP_AND       17'b000000_0000_01_01001
`define OP_OR        17'b000000_0000_01_01010
`define OP_XOR       17'b000000_0000_01_01011
`define OP_SLL_W     17'b000000_0000_01_01110
`define OP_SRL_W     17'b000000_0000_01_01111
`define OP_SRA_W     17'b000000_0000_01_10000
`define OP_SLLI_W    17'b000000_0001_00_00001
`define OP_SRLI_W    17'b000000_0001_00_01001
`define OP_SRAI_W    17'b000000_0001_00_10001
`define OP_SLTI      17'b000000_1000_??_?????
`define OP_SLTUI     17'b000000_1001_??_?????
`define OP_ADDI_W    17'b000000_1010_??_?????
`define OP_ANDI      17'b000000_1101_??_?????
`define OP_ORI       17'b000000_1110_??_?????
`define OP_XORI      17'b000000_1111_??_?????
`define OP_LU12I_W   17'b000101_0???_??_?????
`define OP_PCADDU12I 17'b000111_0???_??_?????
`define OP_LD_B      17'b001010_0000_??_?????
`define OP_LD_H      17'b001010_0001_??_?????
`define OP_LD_W      17'b001010_0010_??_?????
`define OP_ST_B      17'b001010_0100_??_?????
`define OP_ST_H      17'b001010_0101_??_?????
`define OP_ST_W      17'b001010_0110_??_?????
`define OP_LD_BU     17'b001010_1000_??_?????
`define OP_LD_HU     17'b001010_1001_??_?????
`define OP_JIRL      17'b010011_????_??_?????
`define OP_B         17'b010100_????_??_?????
`define OP_BL        17'b010101_????_??_?????
`define OP_BEQ       17'b010110_????_??_?????
`define OP_BNE       17'b010111_????_??_?????
`define OP_BLT       17'b011000_????_??_?????
`define OP_BGE       17'b011001_????_??_?????
`define OP_BLTU      17'b011010_????_??_?????
`define OP_BGEU      17'b011011_????_??_?????

`endif

//--- hdl/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

  typedef struct packed {
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] inst;
  } fetch_bus_t;

  // data_ok low while the producer has no result yet
  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`DATA_W-1:0]     data;
    logic                   data_ok;
  } fwd_t;

  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]     data;
  } reg_write_t;

  // one-hot, add in bit 0
  typedef struct packed {
    logic lui;
    logic sra;
    logic srl;
    logic sll;
    logic bit_xor;
    logic bit_or;
    logic bit_nor;
    logic bit_and;
    logic sltu;
    logic slt;
    logic sub;
    logic add;
  } alu_op_t;

  typedef struct packed {
    logic hu;
    logic bu;
    logic w;
    logic h;
    logic b;
  } load_op_t;

  typedef struct packed {
    logic w;
    logic h;
    logic b;
  } store_op_t;

  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_b,
    br_bl,
    br_jirl
  } br_kind_t;

  typedef struct packed {
    alu_op_t                alu_op;
    load_op_t               load_op;
    store_op_t              store_op;
    br_kind_t               br_kind;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic [`DATA_W-1:0]     imm;
    logic [`DATA_W-1:0]     br_offs;
    logic                   gr_we;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   uses_rj;
    logic                   uses_rkd;
  } decoded_t;

  typedef struct packed {
    logic [`DATA_W-1:0] rj_value;
    logic [`DATA_W-1:0] rkd_value;
    logic               rj_wait;
    logic               rkd_wait;
  } operands_t;

  typedef struct packed {
    logic [`DATA_W-1:0]     pc;
    alu_op_t                alu_op;
    load_op_t               load_op;
    store_op_t              store_op;
    logic [`DATA_W-1:0]     src1;
    logic [`DATA_W-1:0]     src2;
    logic [`DATA_W-1:0]     rkd_value;
    logic                   gr_we;
    logic [`REG_ADDR_W-1:0] dest;
  } issue_bus_t;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module reg_file (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] raddr1,
  input  logic [`REG_ADDR_W-1:0] raddr2,
  output logic [`DATA_W-1:0]     rdata1,
  output logic [`DATA_W-1:0]     rdata2,
  input  decode_pkg::reg_write_t wb
);

  logic [`DATA_W-1:0] regs [`REG_NUM];

  always_ff @(posedge clk) begin
    if (wb.we && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // r0 is never written, so read it as a constant
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module inst_decoder (
  input  logic [`DATA_W-1:0]     inst,
  output decode_pkg::decoded_t   dec,
  output logic [`REG_ADDR_W-1:0] raddr1,
  output logic [`REG_ADDR_W-1:0] raddr2
);

  logic [16:0]            op;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`REG_ADDR_W-1:0] rj;
  logic [`REG_ADDR_W-1:0] rk;
  logic [11:0]            i12;
  logic [15:0]            i16;
  logic [19:0]            i20;
  logic [25:0]            i26;

  logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
  logic inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
  logic inst_slli_w, inst_srli_w, inst_srai_w;
  logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic inst_lu12i_w, inst_pcaddu12i, inst_jirl, inst_b, inst_bl;
  logic is_3r, is_load, is_store, is_cond_br;
  logic need_si12, need_ui12, need_ui20, src2_is_4;

  decode_pkg::alu_op_t    alu_op;
  decode_pkg::load_op_t   load_op;
  decode_pkg::store_op_t  store_op;
  decode_pkg::br_kind_t   br_kind;
  logic [`DATA_W-1:0]     imm;
  logic [`DATA_W-1:0]     br_offs;

  assign op  = inst[31:15];
  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i16 = inst[25:10];
  assign i20 = inst[24:5];
  assign i26 = {inst[9:0], inst[25:10]};

  assign inst_add_w     = op ==? `OP_ADD_W;
  assign inst_sub_w     = op ==? `OP_SUB_W;
  assign inst_slt       = op ==? `OP_SLT;
  assign inst_sltu      = op ==? `OP_SLTU;
  assign inst_nor       = op ==? `OP_NOR;
  assign inst_and       = op ==? `OP_AND;
  assign inst_or        = op ==? `OP_OR;
  assign inst_xor       = op ==? `OP_XOR;
  assign inst_sll_w     = op ==? `OP_SLL_W;
  assign inst_srl_w     = op ==? `OP_SRL_W;
  assign inst_sra_w     = op ==? `OP_SRA_W;
  assign inst_slli_w    = op ==? `OP_SLLI_W;
  assign inst_srli_w    = op ==? `OP_SRLI_W;
  assign inst_srai_w    = op ==? `OP_SRAI_W;
  assign inst_addi_w    = op ==? `OP_ADDI_W;
  assign inst_slti      = op ==? `OP_SLTI;
  assign inst_sltui     = op ==? `OP_SLTUI;
  assign inst_andi      = op ==? `OP_ANDI;
  assign inst_ori       = op ==? `OP_ORI;
  assign inst_xori      = op ==? `OP_XORI;
  assign inst_lu12i_w   = op ==? `OP_LU12I_W;
  assign inst_pcaddu12i = op ==? `OP_PCADDU12I;

  assign load_op.b   = op ==? `OP_LD_B;
  assign load_op.h   = op ==? `OP_LD_H;
  assign load_op.w   = op ==? `OP_LD_W;
  assign load_op.bu  = op ==? `OP_LD_BU;
  assign load_op.hu  = op ==? `OP_LD_HU;
  assign store_op.b  = op ==? `OP_ST_B;
  assign store_op.h  = op ==? `OP_ST_H;
  assign store_op.w  = op ==? `OP_ST_W;

  always_comb begin
    unique casez (op)
      `OP_BEQ:  br_kind = decode_pkg::br_beq;
      `OP_BNE:  br_kind = decode_pkg::br_bne;
      `OP_BLT:  br_kind = decode_pkg::br_blt;
      `OP_BGE:  br_kind = decode_pkg::br_bge;
      `OP_BLTU: br_kind = decode_pkg::br_bltu;
      `OP_BGEU: br_kind = decode_pkg::br_bgeu;
      `OP_B:    br_kind = decode_pkg::br_b;
      `OP_BL:   br_kind = decode_pkg::br_bl;
      `OP_JIRL: br_kind = decode_pkg::br_jirl;
      default:  br_kind = decode_pkg::br_none;
    endcase
  end

  assign inst_jirl  = br_kind == decode_pkg::br_jirl;
  assign inst_b     = br_kind == decode_pkg::br_b;
  assign inst_bl    = br_kind == decode_pkg::br_bl;
  assign is_cond_br = br_kind inside {decode_pkg::br_beq, decode_pkg::br_bne,
                                      decode_pkg::br_blt, decode_pkg::br_bge,
                                      decode_pkg::br_bltu, decode_pkg::br_bgeu};
  assign is_load    = |load_op;
  assign is_store   = |store_op;
  assign is_3r      = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                    | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;

  // address generation and link values also go through the adder
  assign alu_op.add     = inst_add_w | inst_addi_w | is_load | is_store | inst_jirl | inst_bl
                        | inst_pcaddu12i;
  assign alu_op.sub     = inst_sub_w;
  assign alu_op.slt     = inst_slt | inst_slti;
  assign alu_op.sltu    = inst_sltu | inst_sltui;
  assign alu_op.bit_and = inst_and | inst_andi;
  assign alu_op.bit_nor = inst_nor;
  assign alu_op.bit_or  = inst_or | inst_ori;
  assign alu_op.bit_xor = inst_xor | inst_xori;
  assign alu_op.sll     = inst_sll_w | inst_slli_w;
  assign alu_op.srl     = inst_srl_w | inst_srli_w;
  assign alu_op.sra     = inst_sra_w | inst_srai_w;
  assign alu_op.lui     = inst_lu12i_w;

  assign src2_is_4 = inst_jirl | inst_bl;
  assign need_ui20 = inst_lu12i_w | inst_pcaddu12i;
  assign need_ui12 = inst_andi | inst_ori | inst_xori;
  assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_slli_w | inst_srli_w
                   | inst_srai_w | is_load | is_store;

  assign imm = src2_is_4 ? `DATA_W'd4 :
               need_ui20 ? {i20, 12'b0} :
               need_si12 ? {{20{i12[11]}}, i12} :
               need_ui12 ? {20'b0, i12} : '0;

  assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

  assign raddr1 = rj;
  assign raddr2 = (is_store | is_cond_br) ? rd : rk;

  assign dec = '{
    alu_op:      alu_op,
    load_op:     load_op,
    store_op:    store_op,
    br_kind:     br_kind,
    src1_is_pc:  inst_jirl | inst_bl | inst_pcaddu12i,
    src2_is_imm: src2_is_4 | need_ui20 | need_si12 | need_ui12,
    imm:         imm,
    br_offs:     br_offs,
    gr_we:       ~is_store & (br_kind == decode_pkg::br_none | inst_jirl | inst_bl),
    dest:        inst_bl ? `REG_ADDR_W'd1 : rd,
    uses_rj:     ~(inst_b | inst_bl | inst_lu12i_w | inst_pcaddu12i),
    uses_rkd:    is_3r | is_store | is_cond_br
  };

endmodule

//--- hdl/operand_fetch.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module operand_fetch (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] raddr1,
  input  logic [`REG_ADDR_W-1:0] raddr2,
  input  decode_pkg::fwd_t       exe_fwd,
  input  decode_pkg::fwd_t       mem_fwd,
  input  decode_pkg::reg_write_t wb,
  output decode_pkg::operands_t  ops
);

  logic [`DATA_W-1:0] rdata1;
  logic [`DATA_W-1:0] rdata2;
  // wait flag on top of the value
  logic [`DATA_W:0]   rj_res;
  logic [`DATA_W:0]   rkd_res;

  reg_file u_reg_file (
    .clk    (clk),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  // youngest producer first, register file last
  function automatic logic [`DATA_W:0] resolve(input logic [`REG_ADDR_W-1:0] addr,
                                                input logic [`DATA_W-1:0]     rf_data);
    if (addr == '0) begin
      return '0;
    end
    if (exe_fwd.we && exe_fwd.dest == addr) begin
      return {~exe_fwd.data_ok, exe_fwd.data};
    end
    if (mem_fwd.we && mem_fwd.dest == addr) begin
      return {~mem_fwd.data_ok, mem_fwd.data};
    end
    if (wb.we && wb.addr == addr) begin
      return {1'b0, wb.data};
    end
    return {1'b0, rf_data};
  endfunction

  always_comb begin
    rj_res  = resolve(raddr1, rdata1);
    rkd_res = resolve(raddr2, rdata2);
  end

  assign ops = '{
    rj_value:  rj_res[`DATA_W-1:0],
    rkd_value: rkd_res[`DATA_W-1:0],
    rj_wait:   rj_res[`DATA_W],
    rkd_wait:  rkd_res[`DATA_W]
  };

endmodule

//--- hdl/issue_control.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module issue_control (
  input  logic                   stage_valid,
  input  logic [`DATA_W-1:0]     pc,
  input  decode_pkg::decoded_t   dec,
  input  decode_pkg::operands_t  ops,
  output logic                   ready_go,
  output logic                   out_valid,
  output decode_pkg::issue_bus_t out_bus,
  output logic                   br_taken,
  output logic [`DATA_W-1:0]     br_target
);

  logic               rj_eq_rkd;
  logic               rj_lt_rkd;
  logic               rj_ltu_rkd;
  logic               cond_met;
  logic [`DATA_W-1:0] br_base;

  // a pending source only matters if the instruction reads it
  assign ready_go  = ~(dec.uses_rj & ops.rj_wait) & ~(dec.uses_rkd & ops.rkd_wait);
  assign out_valid = stage_valid & ready_go;

  assign rj_eq_rkd  = ops.rj_value == ops.rkd_value;
  assign rj_lt_rkd  = $signed(ops.rj_value) < $signed(ops.rkd_value);
  assign rj_ltu_rkd = ops.rj_value < ops.rkd_value;

  always_comb begin
    unique case (dec.br_kind)
      decode_pkg::br_beq:  cond_met = rj_eq_rkd;
      decode_pkg::br_bne:  cond_met = ~rj_eq_rkd;
      decode_pkg::br_blt:  cond_met = rj_lt_rkd;
      decode_pkg::br_bge:  cond_met = ~rj_lt_rkd;
      decode_pkg::br_bltu: cond_met = rj_ltu_rkd;
      decode_pkg::br_bgeu: cond_met = ~rj_ltu_rkd;
      decode_pkg::br_b,
      decode_pkg::br_bl,
      decode_pkg::br_jirl: cond_met = 1'b1;
      default:             cond_met = 1'b0;
    endcase
  end

  assign br_taken = out_valid & cond_met;

  // jirl is register relative, every other branch is pc relative
  assign br_base   = (dec.br_kind == decode_pkg::br_jirl) ? ops.rj_value : pc;
  assign br_target = br_base + dec.br_offs;

  assign out_bus = '{
    pc:        pc,
    alu_op:    dec.alu_op,
    load_op:   dec.load_op,
    store_op:  dec.store_op,
    src1:      dec.src1_is_pc ? pc : ops.rj_value,
    src2:      dec.src2_is_imm ? dec.imm : ops.rkd_value,
    rkd_value: ops.rkd_value,
    gr_we:     dec.gr_we,
    dest:      dec.dest
  };

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  decode_pkg::fetch_bus_t in_bus,
  output logic                   allowin,
  input  decode_pkg::fwd_t       exe_fwd,
  input  decode_pkg::fwd_t       mem_fwd,
  input  decode_pkg::reg_write_t wb,
  output logic                   out_valid,
  input  logic                   out_allowin,
  output decode_pkg::issue_bus_t out_bus,
  output logic                   br_taken,
  output logic [`DATA_W-1:0]     br_target
);

  logic                   stage_valid;
  logic                   ready_go;
  decode_pkg::fetch_bus_t fetch_q;
  decode_pkg::decoded_t   dec;
  decode_pkg::operands_t  ops;
  logic [`REG_ADDR_W-1:0] raddr1;
  logic [`REG_ADDR_W-1:0] raddr2;

  assign allowin = ~stage_valid | (ready_go & out_allowin);

  // taken branch kills whatever would follow it
  always_ff @(posedge clk) begin
    if (reset || br_taken) begin
      stage_valid <= 1'b0;
    end else if (allowin) begin
      stage_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      fetch_q <= in_bus;
    end
  end

  inst_decoder u_inst_decoder (
    .inst   (fetch_q.inst),
    .dec    (dec),
    .raddr1 (raddr1),
    .raddr2 (raddr2)
  );

  operand_fetch u_operand_fetch (
    .clk     (clk),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .exe_fwd (exe_fwd),
    .mem_fwd (mem_fwd),
    .wb      (wb),
    .ops     (ops)
  );

  issue_control u_issue_control (
    .stage_valid (stage_valid),
    .pc          (fetch_q.pc),
    .dec         (dec),
    .ops         (ops),
    .ready_go    (ready_go),
    .out_valid   (out_valid),
    .out_bus     (out_bus),
    .br_taken    (br_taken),
    .br_target   (br_target)
  );

endmodule

//--- test/decode_stage_properties.sv
`timescale 1ns/1ps

module decode_stage_properties (
  input logic                   clk,
  input logic                   reset,
  input logic                   out_valid,
  input logic                   out_allowin,
  input decode_pkg::issue_bus_t out_bus,
  input logic                   br_taken
);

  quiet_after_reset: assert property (@(posedge clk) reset |=> !out_valid && !br_taken)
    else $error("out_valid or br_taken high after reset");

  taken_needs_valid: assert property (@(posedge clk) disable iff (reset) br_taken |-> out_valid)
    else $error("br_taken without out_valid");

  // held bundle under back-pressure
  bus_holds: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_allowin |=> $stable(out_bus))
    else $error("out_bus changed while stalled by out_allowin");

endmodule

bind decode_stage decode_stage_properties decode_stage_props (
  .clk         (clk),
  .reset       (reset),
  .out_valid   (out_valid),
  .out_allowin (out_allowin),
  .out_bus     (out_bus),
  .br_taken    (br_taken)
);

//--- test/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage_tb;

  localparam int NUM_TESTS = 400;
  localparam int TIMEOUT   = 50;
  localparam int NUM_KINDS = 39;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   in_valid;
  decode_pkg::fetch_bus_t in_bus;
  logic                   allowin;
  decode_pkg::fwd_t       exe_fwd;
  decode_pkg::fwd_t       mem_fwd;
  decode_pkg::reg_write_t wb;
  logic                   out_valid;
  logic                   out_allowin;
  decode_pkg::issue_bus_t out_bus;
  logic                   br_taken;
  logic [`DATA_W-1:0]     br_target;

  logic [31:0]            rng_state = 32'd43;
  logic [`DATA_W-1:0]     shadow [`REG_NUM];
  int                     errors = 0;
  int                     test_errors;
  logic                   timed_out = 1'b0;
  int                     cur_kind;
  logic [31:0]            cur_inst;
  logic [31:0]            cur_pc;
  decode_pkg::issue_bus_t exp_bus;
  logic                   exp_stall;
  logic                   exp_taken;
  logic [31:0]            exp_target;

  // kinds 0 to 13 are 3R ops and shift immediates
  // kinds 14 to 27 take a 12-bit immediate
  logic [16:0] op17_tab [14] = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a,
                                 17'h2b, 17'h2e, 17'h2f, 17'h30, 17'h81, 17'h89, 17'h91};
  logic [9:0]  op10_tab [14] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f,
                                 10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9,
                                 10'h0a4, 10'h0a5, 10'h0a6};
  // one-hot bit in the order add sub slt sltu and nor or xor sll srl sra lui
  int          alu_tab  [28] = '{0, 1, 2, 3, 5, 4, 6, 7, 8, 9, 10, 8, 9, 10,
                                 2, 3, 0, 4, 6, 7, 0, 0, 0, 0, 0, 0, 0, 0};

  decode_stage decode_stage_inst (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_bus      (in_bus),
    .allowin     (allowin),
    .exe_fwd     (exe_fwd),
    .mem_fwd     (mem_fwd),
    .wb          (wb),
    .out_valid   (out_valid),
    .out_allowin (out_allowin),
    .out_bus     (out_bus),
    .br_taken    (br_taken),
    .br_target   (br_target)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (wb.we && wb.addr != '0) begin
      shadow[wb.addr] <= wb.data;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // kinds 28 and 29 are lu12i.w and pcaddu12i
  // kinds 30 to 38 are jirl b bl beq bne blt bge bltu bgeu
  function automatic logic [31:0] make_inst(input int kind, input logic [31:0] r);
    if (kind < 14) return {op17_tab[kind], r[14:0]};
    if (kind < 28) return {op10_tab[kind-14], r[21:0]};
    if (kind == 28) return {7'h0a, r[24:0]};
    if (kind == 29) return {7'h0e, r[24:0]};
    return {6'h13 + 6'(kind - 30), r[25:0]};
  endfunction

  function automatic logic [4:0] rkd_addr_of(input int kind, input logic [31:0] inst);
    if ((kind >= 25 && kind <= 27) || kind >= 33) return inst[4:0];
    return inst[14:10];
  endfunction

  function automatic logic [4:0] pick_addr(input logic [1:0] sel, input logic [4:0] a,
                                           input logic [4:0] b, input logic [4:0] rnd);
    if (sel == 2'd0) return a;
    if (sel == 2'd1) return b;
    return rnd;
  endfunction

  function automatic decode_pkg::fwd_t random_fwd(input logic [4:0] a, input logic [4:0] b);
    logic [31:0]      r;
    decode_pkg::fwd_t f;
    r = next_rand();
    f.we      = r[0] | r[1];
    f.dest    = pick_addr(r[3:2], a, b, r[8:4]);
    f.data_ok = r[10] | r[11];
    f.data    = next_rand();
    return f;
  endfunction

  // wait flag above the value
  function automatic logic [32:0] fwd_value(input logic [4:0] addr);
    if (addr == 5'd0) return 33'd0;
    if (exe_fwd.we && exe_fwd.dest == addr) return {~exe_fwd.data_ok, exe_fwd.data};
    if (mem_fwd.we && mem_fwd.dest == addr) return {~mem_fwd.data_ok, mem_fwd.data};
    if (wb.we && wb.addr == addr) return {1'b0, wb.data};
    return {1'b0, shadow[addr]};
  endfunction

  task automatic build_expected();
    logic [32:0] rj_res;
    logic [32:0] rkd_res;
    logic        is_store;
    logic        is_cbr;
    logic        uses_rj;
    logic        uses_rkd;
    logic [31:0] imm;
    logic [31:0] offs16;
    logic [11:0] alu;
    int          k;
    k        = cur_kind;
    is_store = k >= 25 && k <= 27;
    is_cbr   = k >= 33;
    rj_res   = fwd_value(cur_inst[9:5]);
    rkd_res  = fwd_value(rkd_addr_of(k, cur_inst));
    uses_rj  = !(k == 28 || k == 29 || k == 31 || k == 32);
    uses_rkd = k <= 10 || is_store || is_cbr;
    exp_stall = (uses_rj && rj_res[32]) || (uses_rkd && rkd_res[32]);
    if (k == 30 || k == 32) imm = 32'd4;
    else if (k == 28 || k == 29) imm = {cur_inst[24:5], 12'b0};
    else if (k >= 17 && k <= 19) imm = {20'b0, cur_inst[21:10]};
    else imm = {{20{cur_inst[21]}}, cur_inst[21:10]};
    if (k < 28) alu = 12'(1) << alu_tab[k];
    else if (k == 28) alu = 12'h800;
    else if (k == 29 || k == 30 || k == 32) alu = 12'h001;
    else alu = 12'h000;
    exp_bus.pc        = cur_pc;
    exp_bus.alu_op    = alu;
    exp_bus.load_op   = (k >= 20 && k <= 24) ? 5'(1) << (k - 20) : 5'd0;
    exp_bus.store_op  = is_store ? 3'(1) << (k - 25) : 3'd0;
    exp_bus.src1      = (k == 29 || k == 30 || k == 32) ? cur_pc : rj_res[31:0];
    exp_bus.src2      = ((k >= 11 && k <= 30) || k == 32) ? imm : rkd_res[31:0];
    exp_bus.rkd_value = rkd_res[31:0];
    exp_bus.gr_we     = !is_store && !(k == 31 || is_cbr);
    exp_bus.dest      = (k == 32) ? 5'd1 : cur_inst[4:0];
    case (k)
      33:         exp_taken = rj_res[31:0] == rkd_res[31:0];
      34:         exp_taken = rj_res[31:0] != rkd_res[31:0];
      35:         exp_taken = $signed(rj_res[31:0]) < $signed(rkd_res[31:0]);
      36:         exp_taken = $signed(rj_res[31:0]) >= $signed(rkd_res[31:0]);
      37:         exp_taken = rj_res[31:0] < rkd_res[31:0];
      38:         exp_taken = rj_res[31:0] >= rkd_res[31:0];
      30, 31, 32: exp_taken = 1'b1;
      default:    exp_taken = 1'b0;
    endcase
    offs16 = {{14{cur_inst[25]}}, cur_inst[25:10], 2'b0};
    if (k == 30) exp_target = rj_res[31:0] + offs16;
    else if (k == 31 || k == 32)
      exp_target = cur_pc + {{4{cur_inst[9]}}, cur_inst[9:0], cur_inst[25:10], 2'b0};
    else exp_target = cur_pc + offs16;
  endtask

  task automatic check_field(input string name, input logic [191:0] got,
                             input logic [191:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bundle();
    build_expected();
    check_field("out_valid", out_valid, 1);
    check_field("out_bus.pc", out_bus.pc, exp_bus.pc);
    check_field("out_bus.alu_op", out_bus.alu_op, exp_bus.alu_op);
    check_field("out_bus.load_op", out_bus.load_op, exp_bus.load_op);
    check_field("out_bus.store_op", out_bus.store_op, exp_bus.store_op);
    check_field("out_bus.src1", out_bus.src1, exp_bus.src1);
    check_field("out_bus.src2", out_bus.src2, exp_bus.src2);
    check_field("out_bus.rkd_value", out_bus.rkd_value, exp_bus.rkd_value);
    check_field("out_bus.gr_we", out_bus.gr_we, exp_bus.gr_we);
    check_field("out_bus.dest", out_bus.dest, exp_bus.dest);
    check_field("br_taken", br_taken, exp_taken);
    if (exp_taken) check_field("br_target", br_target, exp_target);
  endtask

  task automatic report_timeout(input string name);
    $display("Error at %0t ns: timed out waiting for %s", $time, name);
    test_errors++;
    timed_out = 1'b1;
  endtask

  task automatic wait_allowin();
    int n;
    for (n = 0; n < TIMEOUT && allowin !== 1'b1; n++) begin
      @(negedge clk);
    end
    if (allowin !== 1'b1) report_timeout("allowin");
  endtask

  task automatic wait_out_valid();
    int n;
    for (n = 0; n < TIMEOUT && out_valid !== 1'b1; n++) begin
      @(negedge clk);
    end
    if (out_valid !== 1'b1) report_timeout("out_valid");
  endtask

  task automatic run_test(input int t);
    logic [31:0]            r;
    logic                   bp;
    decode_pkg::issue_bus_t held;
    test_errors = 0;
    cur_kind = int'(next_rand() % NUM_KINDS);
    cur_inst = make_inst(cur_kind, next_rand());
    r        = next_rand();
    cur_pc   = {r[31:2], 2'b00};
    bp       = cur_kind < 30 && (next_rand() % 3) == 0;
    wait_allowin();
    if (!timed_out) begin
      @(posedge clk);
      in_valid    <= 1'b1;
      in_bus      <= '{pc: cur_pc, inst: cur_inst};
      exe_fwd     <= random_fwd(cur_inst[9:5], rkd_addr_of(cur_kind, cur_inst));
      mem_fwd     <= random_fwd(cur_inst[9:5], rkd_addr_of(cur_kind, cur_inst));
      wb          <= reg_write_from(random_fwd(cur_inst[9:5],
                                               rkd_addr_of(cur_kind, cur_inst)));
      out_allowin <= !bp;
      @(negedge clk);
      build_expected();
      @(posedge clk);
      // a taken branch must swallow the next fetch already waiting
      if (exp_taken) in_bus <= '{pc: cur_pc + 32'd4, inst: 32'h0010_0000};
      else in_valid <= 1'b0;
      @(negedge clk);
      if (exp_stall) begin
        check_field("out_valid", out_valid, 0);
        @(negedge clk);
        check_field("out_valid", out_valid, 0);
        @(posedge clk);
        exe_fwd.data_ok <= 1'b1;
        mem_fwd.data_ok <= 1'b1;
        wait_out_valid();
      end
    end
    if (!timed_out) begin
      check_bundle();
      if (bp) begin
        check_field("allowin", allowin, 0);
        held = out_bus;
        // another fetch waits behind the held instruction
        @(posedge clk);
        in_valid <= 1'b1;
        in_bus   <= '{pc: cur_pc + 32'd4, inst: 32'h0010_0000};
        repeat (2) @(negedge clk);
        check_field("out_bus", out_bus, held);
        check_field("out_valid", out_valid, 1);
        check_field("allowin", allowin, 0);
        @(posedge clk);
        out_allowin <= 1'b1;
        in_valid    <= 1'b0;
        @(negedge clk);
      end
      if (exp_taken) begin
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_field("out_valid", out_valid, 0);
        check_field("allowin", allowin, 1);
      end
    end
    errors += test_errors;
    $display("test %0d kind %0d: %s", t, cur_kind, test_errors == 0 ? "ok" : "failed");
  endtask

  function automatic decode_pkg::reg_write_t reg_write_from(input decode_pkg::fwd_t f);
    return '{we: f.we & f.data_ok, addr: f.dest, data: f.data};
  endfunction

  initial begin
    int i;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_bus      = '0;
    exe_fwd     = '0;
    mem_fwd     = '0;
    wb          = '0;
    out_allowin = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // fill every register once so reads are defined
    for (i = 1; i < `REG_NUM; i++) begin
      @(posedge clk);
      wb <= '{we: 1'b1, addr: 5'(i), data: next_rand()};
    end
    @(posedge clk);
    wb.we <= 1'b0;
    @(negedge clk);
    for (i = 0; i < NUM_TESTS && !timed_out; i++) begin
      run_test(i);
    end
    $display("%0d tests run, %0d errors", i, errors);
    if (errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
hdl/decode_pkg.sv
hdl/reg_file.sv
hdl/inst_decoder.sv
hdl/operand_fetch.sv
hdl/issue_control.sv
hdl/decode_stage.sv
test/decode_stage_properties.sv
test/decode_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module decode_stage_tb -o decode_stage_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/decode_stage_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
